//--- common/axi3_conv_pkg.sv
package axi3_conv_pkg;

  // AXI field widths
  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LEN4_W = 8;                  // AXI4 arlen
  localparam int LEN3_W = 4;                  // AXI3 arlen
  localparam int SIZE_W = 3;
  localparam int RESP_W = 2;

  // Burst limits
  localparam int MAX_AXI3_BEATS = 16;
  localparam int BEATS_W        = LEN4_W + 1; // Holds 1..256 beats

  localparam logic [BEATS_W-1:0] AXI3_BEATS =
    BEATS_W'(MAX_AXI3_BEATS);
  localparam logic [LEN3_W-1:0]  AXI3_LEN_MAX =
    LEN3_W'(MAX_AXI3_BEATS - 1);
  localparam logic [ADDR_W-1:0]  AXI3_BEATS_ADDR =
    ADDR_W'(MAX_AXI3_BEATS);              // Piece stride before size shift

  // Split flag FIFO between address and data sides
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
  localparam int CMD_CNT_W      = $clog2(CMD_FIFO_DEPTH + 1);

  localparam logic [CMD_PTR_W-1:0] CMD_PTR_LAST =
    CMD_PTR_W'(CMD_FIFO_DEPTH - 1);
  localparam logic [CMD_CNT_W-1:0] CMD_CNT_FULL =
    CMD_CNT_W'(CMD_FIFO_DEPTH);

  // Response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

//--- ar_split/ar_split.sv
`timescale 1ns/1ps

module ar_split (
  input  logic                                  aclk,
  input  logic                                  rst_n,

  // AXI4 request
  input  logic [axi3_conv_pkg::ID_W-1:0]        s_arid,
  input  logic [axi3_conv_pkg::ADDR_W-1:0]      s_araddr,
  input  logic [axi3_conv_pkg::LEN4_W-1:0]      s_arlen,
  input  logic [axi3_conv_pkg::SIZE_W-1:0]      s_arsize,
  input  logic                                  s_arvalid,
  output logic                                  s_arready,

  // AXI3 pieces
  output logic [axi3_conv_pkg::ID_W-1:0]        m_arid,
  output logic [axi3_conv_pkg::ADDR_W-1:0]      m_araddr,
  output logic [axi3_conv_pkg::LEN3_W-1:0]      m_arlen,
  output logic [axi3_conv_pkg::SIZE_W-1:0]      m_arsize,
  output logic                                  m_arvalid,
  input  logic                                  m_arready,

  // Split flag FIFO
  output logic                                  cmd_push,
  output logic                                  cmd_push_split,
  input  logic                                  cmd_full
);

  logic                                 busy;
  logic [axi3_conv_pkg::BEATS_W-1:0]    rem_beats;  // Beats not yet issued
  logic [axi3_conv_pkg::BEATS_W-1:0]    rem_minus_one;
  logic [axi3_conv_pkg::ADDR_W-1:0]     cur_addr;
  logic [axi3_conv_pkg::ADDR_W-1:0]     addr_step;
  logic [axi3_conv_pkg::ID_W-1:0]       id_q;
  logic [axi3_conv_pkg::SIZE_W-1:0]     size_q;
  logic                                 s_ar_hs;
  logic                                 m_ar_hs;
  logic                                 more_pieces;

  assign s_arready = ~busy;
  assign s_ar_hs   = s_arvalid & s_arready;

  // Full can only fall while valid waits, so valid holds once raised
  assign m_arvalid = busy & ~cmd_full;
  assign m_ar_hs   = m_arvalid & m_arready;

  // More than one AXI3 burst left in this request
  assign more_pieces   = rem_beats > axi3_conv_pkg::AXI3_BEATS;
  assign rem_minus_one = rem_beats - 1'b1;

  // One piece covers 16 beats of size bytes each
  assign addr_step = axi3_conv_pkg::AXI3_BEATS_ADDR << size_q;

  assign m_arid   = id_q;
  assign m_araddr = cur_addr;
  assign m_arsize = size_q;
  assign m_arlen  = more_pieces ? axi3_conv_pkg::AXI3_LEN_MAX
                                : rem_minus_one[axi3_conv_pkg::LEN3_W-1:0];

  assign cmd_push       = m_ar_hs;
  assign cmd_push_split = more_pieces;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      rem_beats <= '0;
    end else if (s_ar_hs) begin
      busy      <= 1'b1;
      rem_beats <= {1'b0, s_arlen} + 1'b1;  // arlen is beats minus one
    end else if (m_ar_hs) begin
      if (more_pieces) begin
        rem_beats <= rem_beats - axi3_conv_pkg::AXI3_BEATS;
      end else begin
        busy      <= 1'b0;                  // Last piece sent
        rem_beats <= '0;
      end
    end
  end

  // Request payload
  always_ff @(posedge aclk) begin
    if (s_ar_hs) begin
      id_q     <= s_arid;
      size_q   <= s_arsize;
      cur_addr <= s_araddr;
    end else if (m_ar_hs && more_pieces) begin
      cur_addr <= cur_addr + addr_step;
    end
  end

endmodule

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo (
  input  logic aclk,
  input  logic rst_n,
  input  logic push,
  input  logic push_split,
  input  logic pop,
  output logic full,
  output logic head_valid,
  output logic head_split
);

  logic [axi3_conv_pkg::CMD_FIFO_DEPTH-1:0] mem;   // One split flag per piece
  logic [axi3_conv_pkg::CMD_PTR_W-1:0]      wr_ptr;
  logic [axi3_conv_pkg::CMD_PTR_W-1:0]      rd_ptr;
  logic [axi3_conv_pkg::CMD_CNT_W-1:0]      count;

  assign full       = count == axi3_conv_pkg::CMD_CNT_FULL;
  assign head_valid = count != '0;
  assign head_split = mem[rd_ptr];

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == axi3_conv_pkg::CMD_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == axi3_conv_pkg::CMD_PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_split;
    end
  end

endmodule

//--- rtl/r_axi3_conv.sv
`timescale 1ns/1ps

module r_axi3_conv (
  // Split flag of the piece in flight
  input  logic                                  cmd_valid,
  input  logic                                  cmd_split,
  output logic                                  cmd_ready,

  // AXI4 side
  output logic [axi3_conv_pkg::ID_W-1:0]        s_rid,
  output logic [axi3_conv_pkg::DATA_W-1:0]      s_rdata,
  output logic [axi3_conv_pkg::RESP_W-1:0]      s_rresp,
  output logic                                  s_rlast,
  output logic                                  s_rvalid,
  input  logic                                  s_rready,

  // AXI3 side
  input  logic [axi3_conv_pkg::ID_W-1:0]        m_rid,
  input  logic [axi3_conv_pkg::DATA_W-1:0]      m_rdata,
  input  logic [axi3_conv_pkg::RESP_W-1:0]      m_rresp,
  input  logic                                  m_rlast,
  input  logic                                  m_rvalid,
  output logic                                  m_rready
);

  logic s_stalling;
  logic s_r_hs;

  // No beat goes out before its piece is known
  assign s_rvalid   = m_rvalid & cmd_valid;
  assign s_stalling = s_rvalid & ~s_rready;
  assign m_rready   = cmd_valid & ~s_stalling;
  assign s_r_hs     = s_rvalid & s_rready;

  // Retire the piece on its last beat
  assign cmd_ready = s_r_hs & m_rlast;

  assign s_rid   = m_rid;
  assign s_rdata = m_rdata;
  assign s_rresp = m_rresp;
  assign s_rlast = m_rlast & ~cmd_split;  // Inner piece boundaries hidden

endmodule

//--- rtl/axi3_read_conv.sv
`timescale 1ns/1ps

module axi3_read_conv (
  input  logic                                  aclk,
  input  logic                                  rst_n,

  // AXI4 slave side
  input  logic [axi3_conv_pkg::ID_W-1:0]        s_arid,
  input  logic [axi3_conv_pkg::ADDR_W-1:0]      s_araddr,
  input  logic [axi3_conv_pkg::LEN4_W-1:0]      s_arlen,
  input  logic [axi3_conv_pkg::SIZE_W-1:0]      s_arsize,
  input  logic                                  s_arvalid,
  output logic                                  s_arready,
  output logic [axi3_conv_pkg::ID_W-1:0]        s_rid,
  output logic [axi3_conv_pkg::DATA_W-1:0]      s_rdata,
  output logic [axi3_conv_pkg::RESP_W-1:0]      s_rresp,
  output logic                                  s_rlast,
  output logic                                  s_rvalid,
  input  logic                                  s_rready,

  // AXI3 master side
  output logic [axi3_conv_pkg::ID_W-1:0]        m_arid,
  output logic [axi3_conv_pkg::ADDR_W-1:0]      m_araddr,
  output logic [axi3_conv_pkg::LEN3_W-1:0]      m_arlen,
  output logic [axi3_conv_pkg::SIZE_W-1:0]      m_arsize,
  output logic                                  m_arvalid,
  input  logic                                  m_arready,
  input  logic [axi3_conv_pkg::ID_W-1:0]        m_rid,
  input  logic [axi3_conv_pkg::DATA_W-1:0]      m_rdata,
  input  logic [axi3_conv_pkg::RESP_W-1:0]      m_rresp,
  input  logic                                  m_rlast,
  input  logic                                  m_rvalid,
  output logic                                  m_rready
);

  logic cmd_push;
  logic cmd_push_split;
  logic cmd_full;
  logic cmd_valid;
  logic cmd_split;
  logic cmd_ready;

  ar_split u_ar_split (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .s_arid         (s_arid),
    .s_araddr       (s_araddr),
    .s_arlen        (s_arlen),
    .s_arsize       (s_arsize),
    .s_arvalid      (s_arvalid),
    .s_arready      (s_arready),
    .m_arid         (m_arid),
    .m_araddr       (m_araddr),
    .m_arlen        (m_arlen),
    .m_arsize       (m_arsize),
    .m_arvalid      (m_arvalid),
    .m_arready      (m_arready),
    .cmd_push       (cmd_push),
    .cmd_push_split (cmd_push_split),
    .cmd_full       (cmd_full)
  );

  // Up to CMD_FIFO_DEPTH pieces outstanding
  cmd_fifo u_cmd_fifo (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .push       (cmd_push),
    .push_split (cmd_push_split),
    .pop        (cmd_ready),
    .full       (cmd_full),
    .head_valid (cmd_valid),
    .head_split (cmd_split)
  );

  r_axi3_conv u_r_axi3_conv (
    .cmd_valid (cmd_valid),
    .cmd_split (cmd_split),
    .cmd_ready (cmd_ready),
    .s_rid     (s_rid),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rlast   (s_rlast),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .m_rid     (m_rid),
    .m_rdata   (m_rdata),
    .m_rresp   (m_rresp),
    .m_rlast   (m_rlast),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready)
  );

endmodule

//--- bench/axi3_read_conv_properties.sv
`timescale 1ns/1ps

module axi3_read_conv_properties (
  input logic                                  aclk,
  input logic                                  rst_n,
  input logic [axi3_conv_pkg::ID_W-1:0]        m_arid,
  input logic [axi3_conv_pkg::ADDR_W-1:0]      m_araddr,
  input logic [axi3_conv_pkg::LEN3_W-1:0]      m_arlen,
  input logic [axi3_conv_pkg::SIZE_W-1:0]      m_arsize,
  input logic                                  m_arvalid,
  input logic                                  m_arready,
  input logic [axi3_conv_pkg::ID_W-1:0]        s_rid,
  input logic [axi3_conv_pkg::DATA_W-1:0]      s_rdata,
  input logic [axi3_conv_pkg::RESP_W-1:0]      s_rresp,
  input logic                                  s_rlast,
  input logic                                  s_rvalid,
  input logic                                  s_rready,
  input logic                                  cmd_push,
  input logic                                  cmd_ready
);

  logic [axi3_conv_pkg::CMD_CNT_W:0] occupancy;     // One bit wider to catch overflow
  int                                fail_count = 0;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + cmd_push - cmd_ready;
    end
  end

  ar_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_arvalid && !m_arready |=> m_arvalid && $stable({m_arid, m_araddr, m_arlen, m_arsize}))
    else begin
      $error("m_ar dropped or changed before its handshake");
      fail_count++;
    end

  r_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable({s_rid, s_rdata, s_rresp, s_rlast}))
    else begin
      $error("s_r dropped or changed before its handshake");
      fail_count++;
    end

  fifo_bound: assert property (@(posedge aclk) disable iff (!rst_n)
    int'(occupancy) <= axi3_conv_pkg::CMD_FIFO_DEPTH)
    else begin
      $error("command FIFO holds more entries than its depth");
      fail_count++;
    end

endmodule

bind axi3_read_conv axi3_read_conv_properties u_axi3_read_conv_properties (.*);

//--- bench/tb_axi3_read_conv.sv
`timescale 1ns/1ps

module tb_axi3_read_conv;

  localparam int     NUM_REQS    = 150;
  localparam int     BEAT_BYTES  = 4;                 // Size 2
  localparam longint WATCHDOG_NS = 64'd150 * 256 * 8 * 100;

  typedef struct packed {
    logic [axi3_conv_pkg::ID_W-1:0]   id;
    logic [axi3_conv_pkg::ADDR_W-1:0] addr;
    logic [axi3_conv_pkg::LEN3_W-1:0] len;
  } piece_t;

  typedef struct packed {
    logic [axi3_conv_pkg::ID_W-1:0]   id;
    logic [axi3_conv_pkg::DATA_W-1:0] data;
    logic [axi3_conv_pkg::RESP_W-1:0] resp;
    logic                             last;
  } beat_t;

  logic                              aclk;
  logic                              rst_n;
  logic [axi3_conv_pkg::ID_W-1:0]    s_arid;
  logic [axi3_conv_pkg::ADDR_W-1:0]  s_araddr;
  logic [axi3_conv_pkg::LEN4_W-1:0]  s_arlen;
  logic [axi3_conv_pkg::SIZE_W-1:0]  s_arsize;
  logic                              s_arvalid;
  logic                              s_arready;
  logic [axi3_conv_pkg::ID_W-1:0]    s_rid;
  logic [axi3_conv_pkg::DATA_W-1:0]  s_rdata;
  logic [axi3_conv_pkg::RESP_W-1:0]  s_rresp;
  logic                              s_rlast;
  logic                              s_rvalid;
  logic                              s_rready;
  logic [axi3_conv_pkg::ID_W-1:0]    m_arid;
  logic [axi3_conv_pkg::ADDR_W-1:0]  m_araddr;
  logic [axi3_conv_pkg::LEN3_W-1:0]  m_arlen;
  logic [axi3_conv_pkg::SIZE_W-1:0]  m_arsize;
  logic                              m_arvalid;
  logic                              m_arready;
  logic [axi3_conv_pkg::ID_W-1:0]    m_rid;
  logic [axi3_conv_pkg::DATA_W-1:0]  m_rdata;
  logic [axi3_conv_pkg::RESP_W-1:0]  m_rresp;
  logic                              m_rlast;
  logic                              m_rvalid;
  logic                              m_rready;

  piece_t      exp_pieces[$];
  piece_t      slave_pieces[$];                        // AXI3 slave model backlog
  beat_t       exp_beats[$];
  int          slave_beat;
  int          reqs_issued;
  int          reqs_accepted;
  int          pieces_seen;
  int          beats_seen;
  int          beats_expected;
  int          full_cycles;
  int          error_count;
  int          errors_before;
  int          tests_run;
  int          tests_failed;
  bit          ar_hs;
  bit          mar_hs;
  bit          mr_hs;
  bit          sr_hs;

  axi3_read_conv u_axi3_read_conv (.*);

  always #50 aclk = ~aclk;

  function automatic logic [axi3_conv_pkg::RESP_W-1:0] resp_for(input logic [31:0] addr);
    return addr[12] ? axi3_conv_pkg::RESP_SLVERR : axi3_conv_pkg::RESP_OKAY;
  endfunction

  // Extra weight on the piece boundary lengths
  function automatic logic [7:0] random_len();
    case ($urandom % 8)
      0:       return 8'd0;
      1:       return 8'd15;
      2:       return 8'd16;
      3:       return 8'd255;
      default: return 8'($urandom % 256);
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic end_test(input string name, input int errors_at_start, input string detail);
    tests_run++;
    if (error_count != errors_at_start) begin
      tests_failed++;
      $display("test %s: FAIL %s", name, detail);
    end else begin
      $display("test %s: ok %s", name, detail);
    end
  endtask

  // Reference model of one AXI4 request
  task automatic expect_request(input piece_t req, input int beats);
    int     pieces;
    piece_t p;
    beat_t  b;
    pieces = (beats + 15) / 16;
    for (int k = 0; k < pieces; k++) begin
      p.id   = req.id;
      p.addr = req.addr + 32'(k * 16 * BEAT_BYTES);
      p.len  = (k < pieces - 1) ? 4'd15 : 4'(beats - 1 - 16 * k);
      exp_pieces.push_back(p);
    end
    for (int i = 0; i < beats; i++) begin
      b.id   = req.id;
      b.data = req.addr + 32'(i * BEAT_BYTES);
      b.resp = resp_for(b.data);
      b.last = (i == beats - 1);
      exp_beats.push_back(b);
    end
    beats_expected += beats;
  endtask

  task automatic drive_master();
    if (ar_hs) begin
      s_arvalid = 1'b0;
    end
    if (!s_arvalid && reqs_issued < NUM_REQS && $urandom % 2 == 1) begin
      s_arid    = 4'($urandom);
      s_araddr  = $urandom & ~32'h3;                   // Word aligned
      s_arlen   = random_len();
      s_arsize  = 3'd2;
      s_arvalid = 1'b1;
      reqs_issued++;
    end
  endtask

  task automatic drive_slave();
    logic [31:0] addr;
    if (mr_hs) begin
      if (slave_beat == int'(slave_pieces[0].len)) begin
        slave_pieces.delete(0);
        slave_beat = 0;
      end else begin
        slave_beat++;
      end
    end
    if (!m_rvalid || mr_hs) begin
      m_rvalid = 1'b0;
      if (slave_pieces.size() != 0 && $urandom % 2 == 1) begin
        addr     = slave_pieces[0].addr + 32'(slave_beat * BEAT_BYTES);
        m_rid    = slave_pieces[0].id;
        m_rdata  = addr;                               // Data is the byte address
        m_rresp  = resp_for(addr);
        m_rlast  = slave_beat == int'(slave_pieces[0].len);
        m_rvalid = 1'b1;
      end
    end
  endtask

  task automatic sample_and_check();
    piece_t p;
    beat_t  b;
    ar_hs  = s_arvalid && s_arready;
    mar_hs = m_arvalid && m_arready;
    mr_hs  = m_rvalid && m_rready;
    sr_hs  = s_rvalid && s_rready;
    if (u_axi3_read_conv.cmd_full) begin
      full_cycles++;
    end
    if (ar_hs) begin
      expect_request('{id: s_arid, addr: s_araddr, len: 4'd0}, int'(s_arlen) + 1);
      reqs_accepted++;
    end
    if (mar_hs) begin
      pieces_seen++;
      slave_pieces.push_back('{id: m_arid, addr: m_araddr, len: m_arlen});
      if (exp_pieces.size() == 0) begin
        $display("ERROR at %0t ns: m_ar issued with no AXI4 request pending", $time);
        error_count++;
      end else begin
        p = exp_pieces.pop_front();
        compare("m_arid", m_arid, p.id);
        compare("m_araddr", m_araddr, p.addr);
        compare("m_arlen", m_arlen, p.len);
        compare("m_arsize", m_arsize, 3'd2);
      end
    end
    if (sr_hs) begin
      beats_seen++;
      if (exp_beats.size() == 0) begin
        $display("ERROR at %0t ns: s_r beat with no beat expected", $time);
        error_count++;
      end else begin
        b = exp_beats.pop_front();
        compare("s_rid", s_rid, b.id);
        compare("s_rdata", s_rdata, b.data);
        compare("s_rresp", s_rresp, b.resp);
        compare("s_rlast", s_rlast, b.last);
      end
    end
  endtask

  initial begin
    void'($urandom(8681));
    aclk      = 1'b0;
    rst_n     = 1'b0;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arsize  = 3'd2;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    m_arready = 1'b0;
    m_rid     = '0;
    m_rdata   = '0;
    m_rresp   = '0;
    m_rlast   = 1'b0;
    m_rvalid  = 1'b0;
    repeat (3) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    @(negedge aclk);
    errors_before = error_count;
    compare("s_rvalid", s_rvalid, 1'b0);
    compare("m_arvalid", m_arvalid, 1'b0);
    compare("m_rready", m_rready, 1'b0);
    compare("s_arready", s_arready, 1'b1);
    end_test("reset_state", errors_before, "");

    errors_before = error_count;
    while (reqs_accepted < NUM_REQS || exp_beats.size() != 0) begin
      @(posedge aclk);
      #1;
      drive_master();
      drive_slave();
      m_arready = ($urandom % 4) != 0;
      s_rready  = ($urandom % 4) != 0;
      @(negedge aclk);
      sample_and_check();
    end
    end_test("random_traffic", errors_before, $sformatf("(%0d requests, %0d pieces, %0d beats)",
             reqs_accepted, pieces_seen, beats_seen));

    errors_before = error_count;
    compare("beat total", beats_seen, beats_expected);
    if (exp_pieces.size() != 0) begin
      $display("ERROR at %0t ns: %0d AXI3 pieces never issued", $time, exp_pieces.size());
      error_count++;
    end
    if (full_cycles == 0) begin
      $display("ERROR: command FIFO never filled, so address stall went unexercised");
      error_count++;
    end
    if (u_axi3_read_conv.u_axi3_read_conv_properties.fail_count != 0) begin
      $display("ERROR: %0d property assertions failed during the run",
               u_axi3_read_conv.u_axi3_read_conv_properties.fail_count);
      error_count++;
    end
    end_test("totals_and_stall", errors_before, $sformatf("(%0d full cycles)", full_cycles));

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired at %0t ns, the DUT stopped making progress", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- compile.f
common/axi3_conv_pkg.sv
ar_split/ar_split.sv
rtl/cmd_fifo.sv
rtl/r_axi3_conv.sv
rtl/axi3_read_conv.sv
bench/axi3_read_conv_properties.sv
bench/tb_axi3_read_conv.sv

//--- Bender.yml
package:
  name: axi3_read_conv

sources:
  - common/axi3_conv_pkg.sv
  - ar_split/ar_split.sv
  - rtl/cmd_fifo.sv
  - rtl/r_axi3_conv.sv
  - rtl/axi3_read_conv.sv
  - target: simulation
    files:
      - bench/axi3_read_conv_properties.sv
      - bench/tb_axi3_read_conv.sv
